//--- dv/chdr_clean_tb.sv
/* Directed testbench for the CHDR cleaning pipeline with packet builder,
   stream driver and monitor, value check and the directed tests */

`timescale 1ns/1ps
`default_nettype none

module chdr_clean_tb;

  import chdr_pkg::*;

  typedef struct packed {
    logic              last;
    logic [user_w-1:0] user;
    logic [chdr_w-1:0] data;
  } beat_t;

  localparam int stream_timeout = 2000;

  logic              clk;
  logic              rst;
  logic [chdr_w-1:0] s_axis_tdata;
  logic [user_w-1:0] s_axis_tuser;
  logic              s_axis_tlast;
  logic              s_axis_tvalid;
  logic              s_axis_tready;
  logic [chdr_w-1:0] m_axis_tdata;
  logic [user_w-1:0] m_axis_tuser;
  logic              m_axis_tlast;
  logic              m_axis_tvalid;
  logic              m_axis_tready;

  beat_t send_q[$];
  beat_t exp_q[$];
  int    pkt_count;
  int    seed;

  chdr_tb_clkgen i_clkgen (
    .clk (clk)
  );

  chdr_clean_top i_chdr_clean_top (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
               $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "Stopping on error");
  endtask

  function automatic logic [chdr_w-1:0] make_header(input logic [2:0] ptype,
                                                    input logic [15:0] len,
                                                    input logic [15:0] seq);
    logic [chdr_w-1:0] hdr;
    hdr                    = 64'h0;
    hdr[47:40]             = 8'h5a;
    hdr[type_msb:type_lsb] = ptype;
    hdr[len_msb:len_lsb]   = len;
    hdr[15:0]              = seq;
    return hdr;
  endfunction

  // Queues the sent beats and the beats the filter and trim rules leave
  task automatic queue_packet(input logic [2:0] ptype, input logic [15:0] len,
                              input int nlines);
    logic [chdr_w-1:0] hdr;
    beat_t             beat;
    int                n_keep;
    int                i;
    bit                keep;
    hdr    = make_header(ptype, len, 16'(pkt_count));
    keep   = (ptype != pkt_rsvd3) && (ptype != pkt_rsvd5) && (len != 16'd0);
    n_keep = int'(chdr_lines_in_pkt(hdr));
    // A packet that ends early keeps its own tlast
    if (n_keep > nlines) begin
      n_keep = nlines;
    end
    for (i = 0; i < nlines; i++) begin
      beat.data = (i == 0) ? hdr : {16'hb0d1, 16'(pkt_count), 16'h0, 16'(i)};
      beat.user = {8'(pkt_count), 8'(i)};
      beat.last = (i == nlines - 1);
      send_q.push_back(beat);
      if (keep && (i < n_keep)) begin
        beat.last = (i == n_keep - 1);
        exp_q.push_back(beat);
      end
    end
    pkt_count++;
  endtask

  // Drives queued beats back to back and checks every output beat in order
  task automatic run_stream(input bit rand_ready);
    int    cycles;
    int    rnd;
    bit    in_fire;
    bit    out_fire;
    beat_t got;
    beat_t exp_beat;
    cycles = 0;
    while (((send_q.size() > 0) || (exp_q.size() > 0)) && (cycles < stream_timeout)) begin
      if (send_q.size() > 0) begin
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = send_q[0].data;
        s_axis_tuser  = send_q[0].user;
        s_axis_tlast  = send_q[0].last;
      end else begin
        s_axis_tvalid = 1'b0;
      end
      if (rand_ready) begin
        rnd           = $random(seed);
        m_axis_tready = rnd[0];
      end else begin
        m_axis_tready = 1'b1;
      end
      // Both readys and the output register are stable until the next edge
      in_fire  = s_axis_tvalid && s_axis_tready;
      out_fire = m_axis_tvalid && m_axis_tready;
      got      = '{last: m_axis_tlast, user: m_axis_tuser, data: m_axis_tdata};
      @(posedge clk);
      #1;
      if (in_fire) begin
        void'(send_q.pop_front());
      end
      if (out_fire && (exp_q.size() == 0)) begin
        abort_run("output beat appeared when no beat was expected");
      end else if (out_fire) begin
        exp_beat = exp_q.pop_front();
        check_value("m_axis_tdata", 64'(got.data), 64'(exp_beat.data));
        check_value("m_axis_tuser", 64'(got.user), 64'(exp_beat.user));
        check_value("m_axis_tlast", 64'(got.last), 64'(exp_beat.last));
      end
      cycles++;
    end
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b1;
    if (cycles >= stream_timeout) begin
      abort_run("timeout waiting for the stream to be sent and received");
    end
  endtask

  // No stray beats may follow a finished stream
  task automatic expect_quiet(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      m_axis_tready = 1'b1;
      check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'd0);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic reset_idle();
    check_value("s_axis_tready", 64'(s_axis_tready), 64'd1);
    expect_quiet(8);
  endtask

  task automatic exact_packet();
    queue_packet(pkt_data_no_ts, 16'd24, 3);
    run_stream(1'b0);
    expect_quiet(6);
  endtask

  task automatic trim_extra_lines();
    queue_packet(pkt_data_no_ts, 16'd20, 6);
    queue_packet(pkt_ctrl, 16'd8, 4);
    queue_packet(pkt_data_ts, 16'd16, 2);
    run_stream(1'b0);
    expect_quiet(6);
  endtask

  task automatic drop_bad_packets();
    queue_packet(pkt_strs, 16'd16, 2);
    queue_packet(pkt_rsvd3, 16'd24, 3);
    queue_packet(pkt_mgmt, 16'd24, 3);
    queue_packet(pkt_rsvd5, 16'd16, 4);
    queue_packet(pkt_data_ts, 16'd0, 3);
    // Single-line packet with a reserved type
    queue_packet(pkt_rsvd3, 16'd8, 1);
    queue_packet(pkt_strc, 16'd12, 2);
    run_stream(1'b0);
    expect_quiet(6);
  endtask

  task automatic random_backpressure();
    int         i;
    int         rnd;
    logic [2:0] ptype;
    logic [15:0] len;
    int         nlines;
    for (i = 0; i < 16; i++) begin
      rnd    = $random(seed);
      ptype  = rnd[14:12];
      len    = {10'd0, rnd[8:3]};
      nlines = int'(rnd[11:9]) + 1;
      queue_packet(ptype, len, nlines);
    end
    queue_packet(pkt_data_no_ts, 16'd0, 2);
    queue_packet(pkt_data_no_ts, 16'd40, 7);
    run_stream(1'b1);
    expect_quiet(8);
  endtask

  initial begin
    seed          = 14;
    pkt_count     = 0;
    rst           = 1'b1;
    s_axis_tdata  = '0;
    s_axis_tuser  = '0;
    s_axis_tlast  = 1'b0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_idle();
    exact_packet();
    trim_extra_lines();
    drop_bad_packets();
    random_backpressure();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/chdr_tb_clkgen.sv
/* Testbench clock generator, 4 ns period */

`timescale 1ns/1ps
`default_nettype none

module chdr_tb_clkgen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Half period of 2 ns
  always begin
    #2 clk = ~clk;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CHDR cleaning testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module chdr_clean_tb \
  -o chdr_clean_tb_sim &&
./obj_dir/chdr_clean_tb_sim | tee /dev/stderr | grep -q "^Test passed$" &&
{ echo "Simulation PASS"; exit 0; } ||
{ echo "Simulation FAIL"; exit 1; }

//--- source/chdr_axis_slice.sv
/* AXI-Stream register slice with skid buffer and registered tready */

`timescale 1ns/1ps
`default_nettype none

module chdr_axis_slice (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [chdr_pkg::chdr_w-1:0] s_tdata,
  input  logic [chdr_pkg::user_w-1:0] s_tuser,
  input  logic                        s_tlast,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  output logic [chdr_pkg::chdr_w-1:0] m_tdata,
  output logic [chdr_pkg::user_w-1:0] m_tuser,
  output logic                        m_tlast,
  output logic                        m_tvalid,
  input  logic                        m_tready
);

  import chdr_pkg::*;

  logic [chdr_w-1:0] skid_tdata;
  logic [user_w-1:0] skid_tuser;
  logic              skid_tlast;
  logic              skid_valid;
  logic              s_fire;
  logic              load_out;

  assign s_fire   = s_tvalid & s_tready;
  // Output register may take a new beat when empty or being drained
  assign load_out = m_tready | ~m_tvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_tvalid   <= 1'b0;
      skid_valid <= 1'b0;
      s_tready   <= 1'b1;
    end else if (load_out) begin
      m_tvalid   <= skid_valid | s_fire;
      skid_valid <= 1'b0;
      s_tready   <= 1'b1;
    end else if (s_fire) begin
      // Output stalled, park the beat and close the input
      skid_valid <= 1'b1;
      s_tready   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_out) begin
      if (skid_valid) begin
        m_tdata <= skid_tdata;
        m_tuser <= skid_tuser;
        m_tlast <= skid_tlast;
      end else begin
        m_tdata <= s_tdata;
        m_tuser <= s_tuser;
        m_tlast <= s_tlast;
      end
    end else if (s_fire) begin
      skid_tdata <= s_tdata;
      skid_tuser <= s_tuser;
      skid_tlast <= s_tlast;
    end
  end

  // A stalled output beat must not change or vanish
  a_hold_stalled : assert property (
    @(posedge clk) disable iff (rst)
    (m_tvalid && !m_tready) |=>
      (m_tvalid && $stable(m_tdata) && $stable(m_tuser) && $stable(m_tlast))
  );

endmodule

`default_nettype wire

//--- source/chdr_clean_top.sv
/* CHDR cleaning pipeline top: input slice, type filter, payload trim
   and output slice */

`timescale 1ns/1ps
`default_nettype none

module chdr_clean_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [chdr_pkg::chdr_w-1:0] s_axis_tdata,
  input  logic [chdr_pkg::user_w-1:0] s_axis_tuser,
  input  logic                        s_axis_tlast,
  input  logic                        s_axis_tvalid,
  output logic                        s_axis_tready,
  output logic [chdr_pkg::chdr_w-1:0] m_axis_tdata,
  output logic [chdr_pkg::user_w-1:0] m_axis_tuser,
  output logic                        m_axis_tlast,
  output logic                        m_axis_tvalid,
  input  logic                        m_axis_tready
);

  import chdr_pkg::*;

  // Input slice to filter
  logic [chdr_w-1:0] in_tdata;
  logic [user_w-1:0] in_tuser;
  logic              in_tlast;
  logic              in_tvalid;
  logic              in_tready;

  // Filter to trim
  logic [chdr_w-1:0] flt_tdata;
  logic [user_w-1:0] flt_tuser;
  logic              flt_tlast;
  logic              flt_tvalid;
  logic              flt_tready;

  // Trim to output slice
  logic [chdr_w-1:0] trm_tdata;
  logic [user_w-1:0] trm_tuser;
  logic              trm_tlast;
  logic              trm_tvalid;
  logic              trm_tready;

  chdr_axis_slice i_in_slice (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (s_axis_tdata),
    .s_tuser  (s_axis_tuser),
    .s_tlast  (s_axis_tlast),
    .s_tvalid (s_axis_tvalid),
    .s_tready (s_axis_tready),
    .m_tdata  (in_tdata),
    .m_tuser  (in_tuser),
    .m_tlast  (in_tlast),
    .m_tvalid (in_tvalid),
    .m_tready (in_tready)
  );

  chdr_type_filter i_filter (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (in_tdata),
    .s_tuser  (in_tuser),
    .s_tlast  (in_tlast),
    .s_tvalid (in_tvalid),
    .s_tready (in_tready),
    .m_tdata  (flt_tdata),
    .m_tuser  (flt_tuser),
    .m_tlast  (flt_tlast),
    .m_tvalid (flt_tvalid),
    .m_tready (flt_tready)
  );

  chdr_trim_payload i_trim (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (flt_tdata),
    .s_tuser  (flt_tuser),
    .s_tlast  (flt_tlast),
    .s_tvalid (flt_tvalid),
    .s_tready (flt_tready),
    .m_tdata  (trm_tdata),
    .m_tuser  (trm_tuser),
    .m_tlast  (trm_tlast),
    .m_tvalid (trm_tvalid),
    .m_tready (trm_tready)
  );

  chdr_axis_slice i_out_slice (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (trm_tdata),
    .s_tuser  (trm_tuser),
    .s_tlast  (trm_tlast),
    .s_tvalid (trm_tvalid),
    .s_tready (trm_tready),
    .m_tdata  (m_axis_tdata),
    .m_tuser  (m_axis_tuser),
    .m_tlast  (m_axis_tlast),
    .m_tvalid (m_axis_tvalid),
    .m_tready (m_axis_tready)
  );

endmodule

`default_nettype wire

//--- source/chdr_pkg.sv
/* CHDR bus widths, header field positions, packet type and state enums,
   and the header line-count function */

`default_nettype none

package chdr_pkg;

  // Bus widths
  localparam int chdr_w          = 64;
  localparam int user_w          = 16;
  localparam int line_bytes      = 8;
  localparam int log2_line_bytes = 3;

  // Header field positions, length is total bytes including the header
  localparam int len_lsb  = 16;
  localparam int len_msb  = 31;
  localparam int type_lsb = 53;
  localparam int type_msb = 55;

  typedef enum logic [2:0] {
    pkt_mgmt       = 3'd0,
    pkt_strs       = 3'd1,
    pkt_strc       = 3'd2,
    pkt_rsvd3      = 3'd3,
    pkt_ctrl       = 3'd4,
    pkt_rsvd5      = 3'd5,
    pkt_data_no_ts = 3'd6,
    pkt_data_ts    = 3'd7
  } chdr_pkt_type_e;

  typedef enum logic [1:0] {
    st_header = 2'd0,
    st_body   = 2'd1,
    st_dump   = 2'd2
  } trim_state_e;

  typedef enum logic [1:0] {
    st_first = 2'd0,
    st_pass  = 2'd1,
    st_drop  = 2'd2
  } filter_state_e;

  // Number of bus lines the header length covers, rounded up
  function automatic logic [15:0] chdr_lines_in_pkt(input logic [chdr_w-1:0] hdr);
    logic [16:0] len_ext;
    len_ext = {1'b0, hdr[len_msb:len_lsb]} + 17'(line_bytes - 1);
    return 16'(len_ext >> log2_line_bytes);
  endfunction

endpackage

`default_nettype wire

//--- source/chdr_trim_payload.sv
/* Payload trimmer that cuts each CHDR packet to its header length,
   moves tlast to the true last line and discards trailing lines */

`timescale 1ns/1ps
`default_nettype none

module chdr_trim_payload (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [chdr_pkg::chdr_w-1:0] s_tdata,
  input  logic [chdr_pkg::user_w-1:0] s_tuser,
  input  logic                        s_tlast,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  output logic [chdr_pkg::chdr_w-1:0] m_tdata,
  output logic [chdr_pkg::user_w-1:0] m_tuser,
  output logic                        m_tlast,
  output logic                        m_tvalid,
  input  logic                        m_tready
);

  import chdr_pkg::*;

  trim_state_e state;
  logic [15:0] lines_left;
  logic [15:0] lines_in_pkt;
  logic        last_line;
  logic        s_fire;

  // Line count from the header is valid only in st_header
  assign lines_in_pkt = chdr_lines_in_pkt(s_tdata);
  assign last_line    = (lines_left == 16'd0);
  assign s_fire       = s_tvalid & s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_header;
      lines_left <= 16'd0;
    end else if (s_fire) begin
      case (state)
        st_header: begin
          if (s_tlast) begin
            // Packet ended on its header line
            state <= st_header;
          end else if (lines_in_pkt == 16'd1) begin
            state <= st_dump;
          end else begin
            // Header and the final body line are not counted
            lines_left <= lines_in_pkt - 16'd2;
            state      <= st_body;
          end
        end
        st_body: begin
          if (s_tlast) begin
            state <= st_header;
          end else if (last_line) begin
            state <= st_dump;
          end else begin
            lines_left <= lines_left - 16'd1;
          end
        end
        st_dump: begin
          if (s_tlast) begin
            state <= st_header;
          end
        end
        default: begin
          state <= st_header;
        end
      endcase
    end
  end

  assign m_tdata  = s_tdata;
  assign m_tuser  = s_tuser;
  assign m_tlast  = s_tlast ||
                    ((state == st_header) && (lines_in_pkt == 16'd1)) ||
                    ((state == st_body) && last_line);
  assign m_tvalid = s_tvalid && (state != st_dump);
  // Surplus lines are consumed regardless of downstream
  assign s_tready = m_tready || (state == st_dump);

  // Nothing follows a forced tlast until the input packet ends
  a_no_valid_in_dump : assert property (
    @(posedge clk) disable iff (rst)
    (s_fire && m_tlast && !s_tlast) |=> ((state == st_dump) && !m_tvalid)
  );

endmodule

`default_nettype wire

//--- source/chdr_type_filter.sv
/* Packet filter that discards whole CHDR packets with a reserved type
   or a zero length field */

`timescale 1ns/1ps
`default_nettype none

module chdr_type_filter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [chdr_pkg::chdr_w-1:0] s_tdata,
  input  logic [chdr_pkg::user_w-1:0] s_tuser,
  input  logic                        s_tlast,
  input  logic                        s_tvalid,
  output logic                        s_tready,
  output logic [chdr_pkg::chdr_w-1:0] m_tdata,
  output logic [chdr_pkg::user_w-1:0] m_tuser,
  output logic                        m_tlast,
  output logic                        m_tvalid,
  input  logic                        m_tready
);

  import chdr_pkg::*;

  filter_state_e  state;
  chdr_pkt_type_e pkt_type;
  logic [15:0]    pkt_len;
  logic           bad_hdr;
  logic           drop_now;
  logic           s_fire;

  // Header decode is only meaningful in st_first
  assign pkt_type = chdr_pkt_type_e'(s_tdata[type_msb:type_lsb]);
  assign pkt_len  = s_tdata[len_msb:len_lsb];
  assign bad_hdr  = (pkt_type == pkt_rsvd3) || (pkt_type == pkt_rsvd5) ||
                    (pkt_len == 16'd0);

  // Header line of a bad packet is swallowed as well
  assign drop_now = (state == st_drop) || ((state == st_first) && bad_hdr);
  assign s_fire   = s_tvalid & s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_first;
    end else if (s_fire) begin
      case (state)
        st_first: begin
          if (s_tlast) begin
            state <= st_first;
          end else if (bad_hdr) begin
            state <= st_drop;
          end else begin
            state <= st_pass;
          end
        end
        st_pass: begin
          if (s_tlast) begin
            state <= st_first;
          end
        end
        st_drop: begin
          if (s_tlast) begin
            state <= st_first;
          end
        end
        default: begin
          state <= st_first;
        end
      endcase
    end
  end

  assign m_tdata  = s_tdata;
  assign m_tuser  = s_tuser;
  assign m_tlast  = s_tlast;
  assign m_tvalid = s_tvalid & ~drop_now;
  assign s_tready = m_tready | drop_now;

  // A swallowed line that is not the last keeps the rest of its packet out
  a_no_valid_in_drop : assert property (
    @(posedge clk) disable iff (rst)
    (s_fire && !m_tvalid && !s_tlast) |=> ((state == st_drop) && !m_tvalid)
  );

endmodule

`default_nettype wire

//--- src.f
source/chdr_pkg.sv
source/chdr_axis_slice.sv
source/chdr_type_filter.sv
source/chdr_trim_payload.sv
source/chdr_clean_top.sv
dv/chdr_tb_clkgen.sv
dv/chdr_clean_tb.sv
